// ==== rs_pkg.sv ====
package rs_pkg;

    // Datapath widths.
    parameter int DATA_LEN = 32;
    parameter int ADDR_LEN = 32;
    parameter int RRF_SEL  = 6;

    // Bus 0 carries load results, buses 1 to 4 come from other units.
    parameter int NUM_BUS = 5;

    // A result bus with this tag broadcasts nothing.
    parameter logic [RRF_SEL-1:0] RRF_NONE = '0;

    typedef enum logic {
        MEM_LOAD,
        MEM_STORE
    } mem_op_e;

    typedef enum logic [1:0] {
        MAU_IDLE,
        MAU_BUS,
        MAU_DONE
    } mau_state_e;

endpackage

// ==== source_manager.sv ====
`timescale 1ns/1ps

module source_manager import rs_pkg::*; (
    input  logic [DATA_LEN-1:0]         src_i,
    input  logic                        src_ready_i,
    input  logic [NUM_BUS*DATA_LEN-1:0] result_data_i,
    input  logic [NUM_BUS*RRF_SEL-1:0]  result_tag_i,

    output logic [DATA_LEN-1:0]         src_o,
    output logic                        resolved_o
);

    // A waiting operand holds its producer tag in the low bits.
    always_comb begin
        src_o      = src_i;
        resolved_o = src_ready_i;
        if (!src_ready_i) begin
            // Lowest numbered bus wins.
            for (int b = 0; b < NUM_BUS; b++) begin
                if (!resolved_o &&
                    result_tag_i[b*RRF_SEL +: RRF_SEL] != RRF_NONE &&
                    result_tag_i[b*RRF_SEL +: RRF_SEL] == src_i[RRF_SEL-1:0]) begin
                    src_o      = result_data_i[b*DATA_LEN +: DATA_LEN];
                    resolved_o = 1'b1;
                end
            end
        end
    end

endmodule

// ==== rs_mem_entry.sv ====
`timescale 1ns/1ps

module rs_mem_entry import rs_pkg::*; (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        busy_i,
    input  logic                        wen_i,
    input  logic [ADDR_LEN-1:0]         write_pc_i,
    input  mem_op_e                     write_op_i,
    input  logic [DATA_LEN-1:0]         write_src_op_1_i,
    input  logic [DATA_LEN-1:0]         write_src_op_2_i,
    input  logic                        write_valid_1_i,
    input  logic                        write_valid_2_i,
    input  logic [DATA_LEN-1:0]         write_imm_i,
    input  logic [RRF_SEL-1:0]          write_rrf_tag_i,
    input  logic                        write_dst_val_i,
    input  logic [NUM_BUS*DATA_LEN-1:0] result_data_i,
    input  logic [NUM_BUS*RRF_SEL-1:0]  result_tag_i,

    output logic [DATA_LEN-1:0]         exe_src_op_1_o,
    output logic [DATA_LEN-1:0]         exe_src_op_2_o,
    output logic                        ready_o,
    output logic [ADDR_LEN-1:0]         exe_pc_o,
    output mem_op_e                     exe_op_o,
    output logic [DATA_LEN-1:0]         exe_imm_o,
    output logic [RRF_SEL-1:0]          exe_rrf_tag_o,
    output logic                        exe_dst_val_o
);

    logic [DATA_LEN-1:0] op_1;
    logic [DATA_LEN-1:0] op_2;
    logic                valid_1;
    logic                valid_2;
    logic [DATA_LEN-1:0] cand_op_1;
    logic [DATA_LEN-1:0] cand_op_2;
    logic                cand_valid_1;
    logic                cand_valid_2;
    logic [DATA_LEN-1:0] next_op_1;
    logic [DATA_LEN-1:0] next_op_2;
    logic                next_valid_1;
    logic                next_valid_2;

    // Incoming operands are woken too, so a broadcast during dispatch is not lost.
    assign cand_op_1    = wen_i ? write_src_op_1_i : op_1;
    assign cand_op_2    = wen_i ? write_src_op_2_i : op_2;
    assign cand_valid_1 = wen_i ? write_valid_1_i : valid_1;
    assign cand_valid_2 = wen_i ? write_valid_2_i : valid_2;

    // Bypass: the woken value is visible in the cycle it is broadcast.
    assign ready_o        = busy_i & next_valid_1 & next_valid_2;
    assign exe_src_op_1_o = next_op_1;
    assign exe_src_op_2_o = next_op_2;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_1 <= 1'b0;
            valid_2 <= 1'b0;
        end else begin
            valid_1 <= next_valid_1;
            valid_2 <= next_valid_2;
        end
    end

    always_ff @(posedge clk_i) begin
        op_1 <= next_op_1;
        op_2 <= next_op_2;
        if (wen_i) begin
            exe_pc_o      <= write_pc_i;
            exe_op_o      <= write_op_i;
            exe_imm_o     <= write_imm_i;
            exe_rrf_tag_o <= write_rrf_tag_i;
            exe_dst_val_o <= write_dst_val_i;
        end
    end

    source_manager u_src_1 (
        .src_i         (cand_op_1),
        .src_ready_i   (cand_valid_1),
        .result_data_i (result_data_i),
        .result_tag_i  (result_tag_i),
        .src_o         (next_op_1),
        .resolved_o    (next_valid_1)
    );

    source_manager u_src_2 (
        .src_i         (cand_op_2),
        .src_ready_i   (cand_valid_2),
        .result_data_i (result_data_i),
        .result_tag_i  (result_tag_i),
        .src_o         (next_op_2),
        .resolved_o    (next_valid_2)
    );

endmodule

// ==== rs_mem_station.sv ====
`timescale 1ns/1ps

module rs_mem_station import rs_pkg::*; #(
    parameter int RS_DEPTH = 4
) (
    input  logic                        clk_i,
    input  logic                        reset_i,

    input  logic                        dispatch_valid_i,
    input  logic [ADDR_LEN-1:0]         dispatch_pc_i,
    input  mem_op_e                     dispatch_op_i,
    input  logic [DATA_LEN-1:0]         dispatch_src_1_i,
    input  logic                        dispatch_valid_1_i,
    input  logic [DATA_LEN-1:0]         dispatch_src_2_i,
    input  logic                        dispatch_valid_2_i,
    input  logic [DATA_LEN-1:0]         dispatch_imm_i,
    input  logic [RRF_SEL-1:0]          dispatch_rrf_tag_i,
    input  logic                        dispatch_dst_val_i,
    output logic                        dispatch_ready_o,

    input  logic [NUM_BUS*DATA_LEN-1:0] result_data_i,
    input  logic [NUM_BUS*RRF_SEL-1:0]  result_tag_i,

    input  logic                        issue_ready_i,
    output logic                        issue_valid_o,
    output mem_op_e                     issue_op_o,
    output logic [ADDR_LEN-1:0]         issue_pc_o,
    output logic [DATA_LEN-1:0]         issue_src_1_o,
    output logic [DATA_LEN-1:0]         issue_src_2_o,
    output logic [DATA_LEN-1:0]         issue_imm_o,
    output logic [RRF_SEL-1:0]          issue_rrf_tag_o,
    output logic                        issue_dst_val_o
);

    localparam int PTR_W = $clog2(RS_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [PTR_W-1:0]    head;
    logic [PTR_W-1:0]    tail;
    logic [CNT_W-1:0]    count;
    logic [RS_DEPTH-1:0] busy;
    logic                dispatch_fire;
    logic                issue_fire;

    logic [RS_DEPTH-1:0] ent_ready;
    logic [DATA_LEN-1:0] ent_src_1   [RS_DEPTH];
    logic [DATA_LEN-1:0] ent_src_2   [RS_DEPTH];
    logic [ADDR_LEN-1:0] ent_pc      [RS_DEPTH];
    mem_op_e             ent_op      [RS_DEPTH];
    logic [DATA_LEN-1:0] ent_imm     [RS_DEPTH];
    logic [RRF_SEL-1:0]  ent_rrf_tag [RS_DEPTH];
    logic                ent_dst_val [RS_DEPTH];

    assign dispatch_ready_o = (count != CNT_W'(RS_DEPTH));
    assign dispatch_fire    = dispatch_valid_i & dispatch_ready_o;
    assign issue_fire       = issue_valid_o & issue_ready_i;

    // Only the head may issue, which keeps memory operations in order.
    assign issue_valid_o   = ent_ready[head];
    assign issue_op_o      = ent_op[head];
    assign issue_pc_o      = ent_pc[head];
    assign issue_src_1_o   = ent_src_1[head];
    assign issue_src_2_o   = ent_src_2[head];
    assign issue_imm_o     = ent_imm[head];
    assign issue_rrf_tag_o = ent_rrf_tag[head];
    assign issue_dst_val_o = ent_dst_val[head];

    // ----------------------------------------
    // Queue pointers and occupancy.
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            busy  <= '0;
        end else begin
            if (dispatch_fire) begin
                tail       <= tail + 1'b1;
                busy[tail] <= 1'b1;
            end
            if (issue_fire) begin
                head       <= head + 1'b1;
                busy[head] <= 1'b0;
            end
            case ({dispatch_fire, issue_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ----------------------------------------
    // Entries.
    // ----------------------------------------
    for (genvar i = 0; i < RS_DEPTH; i++) begin : g_entry
        rs_mem_entry u_entry (
            .clk_i            (clk_i),
            .reset_i          (reset_i),
            .busy_i           (busy[i]),
            .wen_i            (dispatch_fire && (tail == PTR_W'(i))),
            .write_pc_i       (dispatch_pc_i),
            .write_op_i       (dispatch_op_i),
            .write_src_op_1_i (dispatch_src_1_i),
            .write_src_op_2_i (dispatch_src_2_i),
            .write_valid_1_i  (dispatch_valid_1_i),
            .write_valid_2_i  (dispatch_valid_2_i),
            .write_imm_i      (dispatch_imm_i),
            .write_rrf_tag_i  (dispatch_rrf_tag_i),
            .write_dst_val_i  (dispatch_dst_val_i),
            .result_data_i    (result_data_i),
            .result_tag_i     (result_tag_i),
            .exe_src_op_1_o   (ent_src_1[i]),
            .exe_src_op_2_o   (ent_src_2[i]),
            .ready_o          (ent_ready[i]),
            .exe_pc_o         (ent_pc[i]),
            .exe_op_o         (ent_op[i]),
            .exe_imm_o        (ent_imm[i]),
            .exe_rrf_tag_o    (ent_rrf_tag[i]),
            .exe_dst_val_o    (ent_dst_val[i])
        );
    end

endmodule

// ==== mem_access_unit.sv ====
`timescale 1ns/1ps

module mem_access_unit import rs_pkg::*; (
    input  logic                clk_i,
    input  logic                reset_i,

    input  logic                issue_valid_i,
    input  mem_op_e             issue_op_i,
    input  logic [ADDR_LEN-1:0] issue_pc_i,
    input  logic [DATA_LEN-1:0] issue_src_1_i,
    input  logic [DATA_LEN-1:0] issue_src_2_i,
    input  logic [DATA_LEN-1:0] issue_imm_i,
    input  logic [RRF_SEL-1:0]  issue_rrf_tag_i,
    input  logic                issue_dst_val_i,
    output logic                issue_ready_o,

    output logic                wb_cyc_o,
    output logic                wb_stb_o,
    output logic                wb_we_o,
    output logic [ADDR_LEN-1:0] wb_adr_o,
    output logic [DATA_LEN-1:0] wb_dat_w_o,
    input  logic [DATA_LEN-1:0] wb_dat_r_i,
    input  logic                wb_ack_i,

    output logic [DATA_LEN-1:0] res_data_o,
    output logic [RRF_SEL-1:0]  res_tag_o,
    output logic                done_valid_o,
    output logic [ADDR_LEN-1:0] done_pc_o
);

    mau_state_e          state;
    mem_op_e             op_q;
    logic [RRF_SEL-1:0]  tag_q;
    logic                dst_val_q;
    logic [ADDR_LEN-1:0] pc_q;
    logic [ADDR_LEN-1:0] adr_q;
    logic [DATA_LEN-1:0] dat_w_q;
    logic [DATA_LEN-1:0] rd_data_q;

    assign issue_ready_o = (state == MAU_IDLE);

    // Classic cycle, held until the slave acks.
    assign wb_cyc_o   = (state == MAU_BUS);
    assign wb_stb_o   = (state == MAU_BUS);
    assign wb_we_o    = (state == MAU_BUS) && (op_q == MEM_STORE);
    assign wb_adr_o   = adr_q;
    assign wb_dat_w_o = dat_w_q;

    // Stores and loads without a destination broadcast nothing.
    assign res_data_o   = rd_data_q;
    assign res_tag_o    = (state == MAU_DONE && op_q == MEM_LOAD && dst_val_q) ? tag_q : RRF_NONE;
    assign done_valid_o = (state == MAU_DONE);
    assign done_pc_o    = pc_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state <= MAU_IDLE;
        end else begin
            case (state)
                MAU_IDLE: if (issue_valid_i) state <= MAU_BUS;
                MAU_BUS:  if (wb_ack_i) state <= MAU_DONE;
                default:  state <= MAU_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == MAU_IDLE && issue_valid_i) begin
            adr_q     <= issue_src_1_i + issue_imm_i;
            dat_w_q   <= issue_src_2_i;
            op_q      <= issue_op_i;
            tag_q     <= issue_rrf_tag_i;
            dst_val_q <= issue_dst_val_i;
            pc_q      <= issue_pc_i;
        end
        if (state == MAU_BUS && wb_ack_i) begin
            rd_data_q <= wb_dat_r_i;
        end
    end

endmodule

// ==== data_ram.sv ====
`timescale 1ns/1ps

module data_ram import rs_pkg::*; #(
    parameter int RAM_WORDS = 256
) (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                wb_cyc_i,
    input  logic                wb_stb_i,
    input  logic                wb_we_i,
    input  logic [ADDR_LEN-1:0] wb_adr_i,
    input  logic [DATA_LEN-1:0] wb_dat_w_i,
    output logic [DATA_LEN-1:0] wb_dat_r_o,
    output logic                wb_ack_o
);

    localparam int IDX_W = $clog2(RAM_WORDS);

    logic [DATA_LEN-1:0] mem [RAM_WORDS];
    logic [IDX_W-1:0]    word_idx;
    logic                access;

    // Word addressed, byte offset bits are ignored.
    assign word_idx = IDX_W'(wb_adr_i[ADDR_LEN-1:2] % RAM_WORDS);
    assign access   = wb_cyc_i & wb_stb_i & ~wb_ack_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wb_ack_o <= 1'b0;
            for (int i = 0; i < RAM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            // Single cycle ack, one cycle after the strobe.
            wb_ack_o <= access;
            if (access && wb_we_i) begin
                mem[word_idx] <= wb_dat_w_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (access) begin
            wb_dat_r_o <= mem[word_idx];
        end
    end

endmodule

// ==== mem_rs_top.sv ====
`timescale 1ns/1ps

module mem_rs_top import rs_pkg::*; #(
    parameter int RS_DEPTH  = 4,
    parameter int RAM_WORDS = 256
) (
    input  logic                            clk_i,
    input  logic                            reset_i,

    input  logic                            dispatch_valid_i,
    input  logic [ADDR_LEN-1:0]             dispatch_pc_i,
    input  mem_op_e                         dispatch_op_i,
    input  logic [DATA_LEN-1:0]             dispatch_src_1_i,
    input  logic                            dispatch_valid_1_i,
    input  logic [DATA_LEN-1:0]             dispatch_src_2_i,
    input  logic                            dispatch_valid_2_i,
    input  logic [DATA_LEN-1:0]             dispatch_imm_i,
    input  logic [RRF_SEL-1:0]              dispatch_rrf_tag_i,
    input  logic                            dispatch_dst_val_i,
    output logic                            dispatch_ready_o,

    input  logic [(NUM_BUS-1)*DATA_LEN-1:0] ext_result_data_i,
    input  logic [(NUM_BUS-1)*RRF_SEL-1:0]  ext_result_tag_i,

    output logic                            done_valid_o,
    output logic [ADDR_LEN-1:0]             done_pc_o,
    output logic [DATA_LEN-1:0]             load_data_o,
    output logic [RRF_SEL-1:0]              load_tag_o
);

    logic [NUM_BUS*DATA_LEN-1:0] result_data;
    logic [NUM_BUS*RRF_SEL-1:0]  result_tag;

    logic                issue_valid;
    logic                issue_ready;
    mem_op_e             issue_op;
    logic [ADDR_LEN-1:0] issue_pc;
    logic [DATA_LEN-1:0] issue_src_1;
    logic [DATA_LEN-1:0] issue_src_2;
    logic [DATA_LEN-1:0] issue_imm;
    logic [RRF_SEL-1:0]  issue_rrf_tag;
    logic                issue_dst_val;

    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [ADDR_LEN-1:0] wb_adr;
    logic [DATA_LEN-1:0] wb_dat_w;
    logic [DATA_LEN-1:0] wb_dat_r;
    logic                wb_ack;

    // Load result sits on bus 0, external units above it.
    assign result_data = {ext_result_data_i, load_data_o};
    assign result_tag  = {ext_result_tag_i, load_tag_o};

    rs_mem_station #(
        .RS_DEPTH (RS_DEPTH)
    ) u_station (
        .clk_i              (clk_i),
        .reset_i            (reset_i),
        .dispatch_valid_i   (dispatch_valid_i),
        .dispatch_pc_i      (dispatch_pc_i),
        .dispatch_op_i      (dispatch_op_i),
        .dispatch_src_1_i   (dispatch_src_1_i),
        .dispatch_valid_1_i (dispatch_valid_1_i),
        .dispatch_src_2_i   (dispatch_src_2_i),
        .dispatch_valid_2_i (dispatch_valid_2_i),
        .dispatch_imm_i     (dispatch_imm_i),
        .dispatch_rrf_tag_i (dispatch_rrf_tag_i),
        .dispatch_dst_val_i (dispatch_dst_val_i),
        .dispatch_ready_o   (dispatch_ready_o),
        .result_data_i      (result_data),
        .result_tag_i       (result_tag),
        .issue_ready_i      (issue_ready),
        .issue_valid_o      (issue_valid),
        .issue_op_o         (issue_op),
        .issue_pc_o         (issue_pc),
        .issue_src_1_o      (issue_src_1),
        .issue_src_2_o      (issue_src_2),
        .issue_imm_o        (issue_imm),
        .issue_rrf_tag_o    (issue_rrf_tag),
        .issue_dst_val_o    (issue_dst_val)
    );

    mem_access_unit u_mau (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .issue_valid_i   (issue_valid),
        .issue_op_i      (issue_op),
        .issue_pc_i      (issue_pc),
        .issue_src_1_i   (issue_src_1),
        .issue_src_2_i   (issue_src_2),
        .issue_imm_i     (issue_imm),
        .issue_rrf_tag_i (issue_rrf_tag),
        .issue_dst_val_i (issue_dst_val),
        .issue_ready_o   (issue_ready),
        .wb_cyc_o        (wb_cyc),
        .wb_stb_o        (wb_stb),
        .wb_we_o         (wb_we),
        .wb_adr_o        (wb_adr),
        .wb_dat_w_o      (wb_dat_w),
        .wb_dat_r_i      (wb_dat_r),
        .wb_ack_i        (wb_ack),
        .res_data_o      (load_data_o),
        .res_tag_o       (load_tag_o),
        .done_valid_o    (done_valid_o),
        .done_pc_o       (done_pc_o)
    );

    data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_ram (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .wb_cyc_i   (wb_cyc),
        .wb_stb_i   (wb_stb),
        .wb_we_i    (wb_we),
        .wb_adr_i   (wb_adr),
        .wb_dat_w_i (wb_dat_w),
        .wb_dat_r_o (wb_dat_r),
        .wb_ack_o   (wb_ack)
    );

endmodule

// ==== tb_mem_rs.sv ====
`timescale 1ns/1ps

module tb_mem_rs import rs_pkg::*; ();

    localparam int RS_DEPTH    = 4;
    localparam int RAM_WORDS   = 256;
    localparam int NUM_OPS     = 120;
    localparam int BURST_FIRST = 40;
    localparam int BURST_LAST  = 56;
    localparam int CYCLE_LIMIT = NUM_OPS * 40 + 200;

    typedef struct packed {
        logic [ADDR_LEN-1:0] pc;
        mem_op_e             op;
        logic                rdy_1;
        logic                known_1;
        logic [DATA_LEN-1:0] val_1;
        logic [RRF_SEL-1:0]  tag_1;
        logic                rdy_2;
        logic                known_2;
        logic [DATA_LEN-1:0] val_2;
        logic [RRF_SEL-1:0]  tag_2;
        logic [DATA_LEN-1:0] imm;
        logic [RRF_SEL-1:0]  tag;
        logic                dst_val;
    } model_op_t;

    logic                              clk_i = 1'b0;
    logic                              reset_i;
    logic                              dispatch_valid_i;
    logic [ADDR_LEN-1:0]               dispatch_pc_i;
    mem_op_e                           dispatch_op_i;
    logic [DATA_LEN-1:0]               dispatch_src_1_i;
    logic                              dispatch_valid_1_i;
    logic [DATA_LEN-1:0]               dispatch_src_2_i;
    logic                              dispatch_valid_2_i;
    logic [DATA_LEN-1:0]               dispatch_imm_i;
    logic [RRF_SEL-1:0]                dispatch_rrf_tag_i;
    logic                              dispatch_dst_val_i;
    logic [(NUM_BUS-1)*DATA_LEN-1:0]   ext_result_data_i;
    logic [(NUM_BUS-1)*RRF_SEL-1:0]    ext_result_tag_i;
    logic                              dispatch_ready_o;
    logic                              done_valid_o;
    logic [ADDR_LEN-1:0]               done_pc_o;
    logic [DATA_LEN-1:0]               load_data_o;
    logic [RRF_SEL-1:0]                load_tag_o;

    // Reference model state.
    logic [DATA_LEN-1:0] mem_model [RAM_WORDS];
    logic [DATA_LEN-1:0] tag_val   [2**RRF_SEL];
    logic                tag_done  [2**RRF_SEL];
    model_op_t           model_q   [$];
    logic [RRF_SEL-1:0]  pend_tag  [$];
    int                  pend_wait [$];
    logic [RRF_SEL-1:0]  next_tag;
    logic [RRF_SEL-1:0]  last_load_tag;
    logic [RRF_SEL-1:0]  last_bcast_tag;
    logic [31:0]         rng_state;
    int                  ops_sent;
    logic                ready_seen;
    logic                saw_full;
    int                  cycle_count = 0;

    mem_rs_top #(
        .RS_DEPTH  (RS_DEPTH),
        .RAM_WORDS (RAM_WORDS)
    ) UUT (
        .clk_i              (clk_i),
        .reset_i            (reset_i),
        .dispatch_valid_i   (dispatch_valid_i),
        .dispatch_pc_i      (dispatch_pc_i),
        .dispatch_op_i      (dispatch_op_i),
        .dispatch_src_1_i   (dispatch_src_1_i),
        .dispatch_valid_1_i (dispatch_valid_1_i),
        .dispatch_src_2_i   (dispatch_src_2_i),
        .dispatch_valid_2_i (dispatch_valid_2_i),
        .dispatch_imm_i     (dispatch_imm_i),
        .dispatch_rrf_tag_i (dispatch_rrf_tag_i),
        .dispatch_dst_val_i (dispatch_dst_val_i),
        .dispatch_ready_o   (dispatch_ready_o),
        .ext_result_data_i  (ext_result_data_i),
        .ext_result_tag_i   (ext_result_tag_i),
        .done_valid_o       (done_valid_o),
        .done_pc_o          (done_pc_o),
        .load_data_o        (load_data_o),
        .load_tag_o         (load_tag_o)
    );

    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Error: timeout after %0d cycles, %0d operations still outstanding",
                     cycle_count, model_q.size());
            $display("Simulation failed");
            $fatal(1, "run did not finish");
        end
    end

    // ----------------------------------------
    // Helpers.
    // ----------------------------------------
    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [RRF_SEL-1:0] alloc_tag();
        logic [RRF_SEL-1:0] t;
        t = next_tag;
        next_tag = (next_tag == '1) ? RRF_SEL'(1) : next_tag + 1'b1;
        tag_done[t] = 1'b0;
        if (last_load_tag == t) last_load_tag = RRF_NONE;
        if (last_bcast_tag == t) last_bcast_tag = RRF_NONE;
        return t;
    endfunction

    function automatic logic burst_phase();
        return ops_sent >= BURST_FIRST && ops_sent < BURST_LAST;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "check failed");
        end
    endtask

    // An operand is a plain value, waits on a pending load or external tag,
    // or reuses a tag that was already broadcast.
    task automatic make_operand(input logic is_addr, input logic allow_ext,
                                output logic rdy, output logic known,
                                output logic [DATA_LEN-1:0] v, output logic [RRF_SEL-1:0] t);
        logic [31:0]         r;
        logic [DATA_LEN-1:0] fresh;
        r = xorshift32();
        fresh = is_addr ? (r & 32'h3c) : xorshift32();
        rdy   = 1'b1;
        known = 1'b1;
        v     = fresh;
        t     = RRF_NONE;
        case (r[9:8])
            2'd1: begin
                if (last_load_tag != RRF_NONE && !tag_done[last_load_tag]) begin
                    rdy   = 1'b0;
                    known = 1'b0;
                    t     = last_load_tag;
                end
            end
            2'd2: begin
                if (allow_ext) begin
                    t = alloc_tag();
                    tag_val[t] = fresh;
                    rdy = 1'b0;
                    pend_tag.push_back(t);
                    pend_wait.push_back(int'(r[14:12]));
                end
            end
            2'd3: begin
                if (last_bcast_tag != RRF_NONE && tag_done[last_bcast_tag])
                    v = tag_val[last_bcast_tag];
            end
            default: ;
        endcase
    endtask

    task automatic drive_dispatch();
        model_op_t   o;
        logic [31:0] r;
        r = xorshift32();
        o.pc      = 32'h0000_1000 + (32'(ops_sent) << 2);
        o.op      = r[0] ? MEM_STORE : MEM_LOAD;
        o.imm     = {27'd0, r[4:2], 2'b00};
        o.tag     = alloc_tag();
        o.dst_val = (o.op == MEM_LOAD) && (r[7:5] != 3'd0);
        make_operand(1'b1, !burst_phase(), o.rdy_1, o.known_1, o.val_1, o.tag_1);
        make_operand(1'b0, !burst_phase(), o.rdy_2, o.known_2, o.val_2, o.tag_2);
        if (o.dst_val) last_load_tag = o.tag;
        dispatch_valid_i   <= 1'b1;
        dispatch_pc_i      <= o.pc;
        dispatch_op_i      <= o.op;
        dispatch_src_1_i   <= o.rdy_1 ? o.val_1 : DATA_LEN'(o.tag_1);
        dispatch_valid_1_i <= o.rdy_1;
        dispatch_src_2_i   <= o.rdy_2 ? o.val_2 : DATA_LEN'(o.tag_2);
        dispatch_valid_2_i <= o.rdy_2;
        dispatch_imm_i     <= o.imm;
        dispatch_rrf_tag_i <= o.tag;
        dispatch_dst_val_i <= o.dst_val;
        model_q.push_back(o);
        ops_sent++;
    endtask

    // At most one external tag per cycle, on a random bus; idle buses carry junk data.
    task automatic drive_broadcast();
        logic [(NUM_BUS-1)*DATA_LEN-1:0] data;
        logic [(NUM_BUS-1)*RRF_SEL-1:0]  tags;
        logic [31:0]                     r;
        int                              found;
        int                              bus;
        data  = {xorshift32(), xorshift32(), xorshift32(), xorshift32()};
        tags  = '0;
        found = -1;
        for (int k = 0; k < pend_wait.size(); k++) begin
            if (pend_wait[k] > 0) pend_wait[k] = pend_wait[k] - 1;
            if (found < 0 && pend_wait[k] == 0) found = k;
        end
        if (found >= 0) begin
            r   = xorshift32();
            bus = int'(r[1:0]);
            tags[bus*RRF_SEL +: RRF_SEL]   = pend_tag[found];
            data[bus*DATA_LEN +: DATA_LEN] = tag_val[pend_tag[found]];
            tag_done[pend_tag[found]] = 1'b1;
            last_bcast_tag = pend_tag[found];
            pend_tag.delete(found);
            pend_wait.delete(found);
        end
        ext_result_data_i <= data;
        ext_result_tag_i  <= tags;
    endtask

    // ----------------------------------------
    // Completion checks against the model.
    // ----------------------------------------
    task automatic retire_op();
        model_op_t           o;
        logic [DATA_LEN-1:0] s1;
        logic [DATA_LEN-1:0] s2;
        logic [ADDR_LEN-1:0] a;
        logic [DATA_LEN-1:0] expected;
        int                  idx;
        if (model_q.size() == 0) begin
            $display("Error: completion reported at pc %h with no operation outstanding",
                     done_pc_o);
            $display("Simulation failed");
            $fatal(1, "unexpected completion");
        end else begin
            o = model_q.pop_front();
            check_value("program order pc", o.pc, done_pc_o);
            s1  = o.known_1 ? o.val_1 : tag_val[o.tag_1];
            s2  = o.known_2 ? o.val_2 : tag_val[o.tag_2];
            a   = s1 + o.imm;
            idx = int'((a >> 2) % 32'(RAM_WORDS));
            if (o.op == MEM_STORE) begin
                mem_model[idx] = s2;
                check_value("store bus 0 tag", 32'(RRF_NONE), 32'(load_tag_o));
            end else if (o.dst_val) begin
                expected = mem_model[idx];
                check_value("load tag", 32'(o.tag), 32'(load_tag_o));
                check_value("load data", expected, load_data_o);
                tag_val[o.tag]  = expected;
                tag_done[o.tag] = 1'b1;
                last_bcast_tag  = o.tag;
            end else begin
                check_value("load without destination tag", 32'(RRF_NONE), 32'(load_tag_o));
            end
        end
    endtask

    task automatic observe_cycle();
        int held;
        // Operations in the station or the unit; a pending dispatch is not yet inside.
        held = model_q.size() - (dispatch_valid_i ? 1 : 0);
        check_value("occupancy bound", 32'd1, 32'(held <= RS_DEPTH + 1));
        if (dispatch_valid_i)
            check_value("dispatch accept", 32'd1, 32'(dispatch_ready_o));
        if (!dispatch_ready_o) begin
            saw_full = 1'b1;
            check_value("full when not ready", 32'd1, 32'(held >= RS_DEPTH));
        end
        ready_seen = dispatch_ready_o;
        if (done_valid_o)
            retire_op();
        else
            check_value("idle bus 0 tag", 32'(RRF_NONE), 32'(load_tag_o));
    endtask

    // ----------------------------------------
    // Main sequence.
    // ----------------------------------------
    initial begin
        logic [31:0] r;
        rng_state          = 32'h4a13;
        next_tag           = RRF_SEL'(1);
        last_load_tag      = RRF_NONE;
        last_bcast_tag     = RRF_NONE;
        ops_sent           = 0;
        saw_full           = 1'b0;
        ready_seen         = 1'b0;
        for (int i = 0; i < RAM_WORDS; i++) mem_model[i] = '0;
        for (int i = 0; i < 2**RRF_SEL; i++) begin
            tag_val[i]  = '0;
            tag_done[i] = 1'b0;
        end
        reset_i            = 1'b1;
        dispatch_valid_i   = 1'b0;
        dispatch_pc_i      = '0;
        dispatch_op_i      = MEM_LOAD;
        dispatch_src_1_i   = '0;
        dispatch_valid_1_i = 1'b0;
        dispatch_src_2_i   = '0;
        dispatch_valid_2_i = 1'b0;
        dispatch_imm_i     = '0;
        dispatch_rrf_tag_i = RRF_NONE;
        dispatch_dst_val_i = 1'b0;
        ext_result_data_i  = '0;
        ext_result_tag_i   = '0;

        repeat (2) @(posedge clk_i);
        reset_i <= 1'b0;
        @(negedge clk_i);
        check_value("reset dispatch ready", 32'd1, 32'(dispatch_ready_o));
        check_value("reset done valid", 32'd0, 32'(done_valid_o));
        check_value("reset bus 0 tag", 32'(RRF_NONE), 32'(load_tag_o));
        ready_seen = dispatch_ready_o;

        // A new operation is offered only after an idle cycle with ready high,
        // so it is always taken at the next edge.
        while (ops_sent < NUM_OPS || model_q.size() != 0 || pend_tag.size() != 0) begin
            @(posedge clk_i);
            if (dispatch_valid_i) begin
                dispatch_valid_i <= 1'b0;
            end else if (ops_sent < NUM_OPS && ready_seen) begin
                r = xorshift32();
                if (burst_phase() || r[1:0] != 2'b00) drive_dispatch();
            end
            drive_broadcast();
            @(negedge clk_i);
            observe_cycle();
        end

        // Idle cycles after the last completion catch a repeated one.
        repeat (RS_DEPTH * 4) begin
            @(posedge clk_i);
            drive_broadcast();
            @(negedge clk_i);
            observe_cycle();
        end

        check_value("dispatch back-pressure seen", 32'd1, 32'(saw_full));
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== all.f ====
rs_pkg.sv
source_manager.sv
rs_mem_entry.sv
rs_mem_station.sv
mem_access_unit.sv
data_ram.sv
mem_rs_top.sv
tb_mem_rs.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the testbench with Verilator.
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module tb_mem_rs -f all.f
./obj_dir/Vtb_mem_rs
